// File: design/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// bus geometry
`define SOC_DATA_W          32
`define SOC_ADDR_W          32
`define SOC_STRB_W          4

// 256 scratch words
`define SOC_RAM_WORDS_LOG2  8

`define SOC_LED_W           8
`define SOC_KEY_W           2
`define SOC_SW_W            4

// address bits 31:30
`define SOC_REGION_RAM      2'b00
`define SOC_REGION_UNMAPPED 2'b01
`define SOC_REGION_LED      2'b10
`define SOC_REGION_INPUT    2'b11

`define SOC_UNMAPPED_DATA   32'hdead_beef

`endif

// File: design/soc_bus_pkg.sv
`default_nettype none

`include "soc_cfg.svh"

package soc_bus_pkg;

  typedef logic [`SOC_ADDR_W-1:0] bus_addr_t;

  // one bit per byte lane
  typedef logic [`SOC_STRB_W-1:0] bus_strb_t;

  // bus word, either whole or split into byte lanes
  typedef union packed {
    logic [`SOC_DATA_W-1:0]      word;
    logic [`SOC_STRB_W-1:0][7:0] bytes;
  } bus_word_u;

endpackage

`default_nettype wire

// File: design/soc_map_pkg.sv
`default_nettype none

`include "soc_cfg.svh"

package soc_map_pkg;

  // top two address bits
  typedef enum logic [1:0] {
    REGION_RAM      = `SOC_REGION_RAM,
    REGION_UNMAPPED = `SOC_REGION_UNMAPPED,
    REGION_LED      = `SOC_REGION_LED,
    REGION_INPUT    = `SOC_REGION_INPUT
  } region_e;

  // none means the decoder answers by itself
  typedef enum logic [1:0] {
    TARGET_NONE  = 2'd0,
    TARGET_RAM   = 2'd1,
    TARGET_LED   = 2'd2,
    TARGET_INPUT = 2'd3
  } target_e;

endpackage

`default_nettype wire

// File: design/bus_decoder.sv
`default_nettype none

`include "soc_cfg.svh"

module bus_decoder (
  input  wire                     clk,
  input  wire                     i_rst,

  input  wire                     i_req,
  input  wire soc_bus_pkg::bus_addr_t i_addr,
  input  wire soc_bus_pkg::bus_strb_t i_rd_mask,

  input  wire                     i_ram_ack,
  input  wire soc_bus_pkg::bus_word_u i_ram_rdata,
  input  wire                     i_led_ack,
  input  wire soc_bus_pkg::bus_word_u i_led_rdata,
  input  wire                     i_in_ack,
  input  wire soc_bus_pkg::bus_word_u i_in_rdata,

  output logic                    o_ram_req,
  output logic                    o_led_req,
  output logic                    o_in_req,
  output logic                    o_ack,
  output soc_bus_pkg::bus_word_u  o_rdata
);

  soc_map_pkg::region_e   region;
  soc_map_pkg::target_e   target;
  soc_bus_pkg::bus_word_u raw_rdata;
  logic                   unmapped_ack;

  assign region = soc_map_pkg::region_e'(i_addr[`SOC_ADDR_W-1 -: 2]);

  always_comb
  begin
    case (region)
      soc_map_pkg::REGION_RAM:   target = soc_map_pkg::TARGET_RAM;
      soc_map_pkg::REGION_LED:   target = soc_map_pkg::TARGET_LED;
      soc_map_pkg::REGION_INPUT: target = soc_map_pkg::TARGET_INPUT;
      default:                   target = soc_map_pkg::TARGET_NONE;
    endcase
  end

  assign o_ram_req = i_req && (target == soc_map_pkg::TARGET_RAM);
  assign o_led_req = i_req && (target == soc_map_pkg::TARGET_LED);
  assign o_in_req  = i_req && (target == soc_map_pkg::TARGET_INPUT);

  // unmapped region acks like a target would
  always_ff @(posedge clk)
  begin
    if (i_rst)
      unmapped_ack <= 1'b0;
    else
      unmapped_ack <= i_req && (target == soc_map_pkg::TARGET_NONE)
                      && !unmapped_ack;
  end

  always_comb
  begin
    case (target)
      soc_map_pkg::TARGET_RAM:
      begin
        o_ack     = i_ram_ack;
        raw_rdata = i_ram_rdata;
      end
      soc_map_pkg::TARGET_LED:
      begin
        o_ack     = i_led_ack;
        raw_rdata = i_led_rdata;
      end
      soc_map_pkg::TARGET_INPUT:
      begin
        o_ack     = i_in_ack;
        raw_rdata = i_in_rdata;
      end
      default:
      begin
        o_ack          = unmapped_ack;
        raw_rdata.word = `SOC_UNMAPPED_DATA;
      end
    endcase
  end

  // zero the lanes the master did not ask for
  always_comb
  begin
    for (int lane = 0; lane < `SOC_STRB_W; lane++)
    begin
      o_rdata.bytes[lane] = i_rd_mask[lane] ? raw_rdata.bytes[lane] : 8'h00;
    end
  end

  a_one_target: assert property (@(posedge clk) disable iff (i_rst)
    $onehot0({o_ram_req, o_led_req, o_in_req}))
    else $error("more than one target request");

  // ack only while a request has been held since the previous cycle
  a_ack_needs_req: assert property (@(posedge clk) disable iff (i_rst)
    o_ack |-> (i_req && $past(i_req)))
    else $error("ack without a pending request");

endmodule

`default_nettype wire

// File: design/scratch_ram.sv
`default_nettype none

`include "soc_cfg.svh"

module scratch_ram (
  input  wire                         clk,
  input  wire                         i_rst,

  input  wire                         i_req,
  input  wire                         i_write,
  input  wire soc_bus_pkg::bus_addr_t i_addr,
  input  wire soc_bus_pkg::bus_word_u i_wdata,
  input  wire soc_bus_pkg::bus_strb_t i_wr_mask,

  output logic                        o_ack,
  output soc_bus_pkg::bus_word_u      o_rdata
);

  localparam int unsigned RAM_WORDS = 1 << `SOC_RAM_WORDS_LOG2;

  soc_bus_pkg::bus_word_u         mem [RAM_WORDS];
  soc_bus_pkg::bus_word_u         merged;
  logic [`SOC_RAM_WORDS_LOG2-1:0] idx;
  logic                           start;

  // word index, upper bits alias
  assign idx   = i_addr[`SOC_RAM_WORDS_LOG2+1:2];
  assign start = i_req && !o_ack;

  always_comb
  begin
    merged = mem[idx];
    for (int lane = 0; lane < `SOC_STRB_W; lane++)
    begin
      if (i_wr_mask[lane])
        merged.bytes[lane] = i_wdata.bytes[lane];
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_rst)
      o_ack <= 1'b0;
    else
      o_ack <= start;
  end

  // old word comes back on writes too
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      o_rdata <= mem[idx];
      if (i_write)
        mem[idx] <= merged;
    end
  end

  a_ack_single: assert property (@(posedge clk) disable iff (i_rst)
    o_ack |=> !o_ack)
    else $error("ram ack held for two cycles");

endmodule

`default_nettype wire

// File: design/led_port.sv
`default_nettype none

`include "soc_cfg.svh"

module led_port (
  input  wire                         clk,
  input  wire                         i_rst,

  input  wire                         i_req,
  input  wire                         i_write,
  input  wire soc_bus_pkg::bus_word_u i_wdata,
  input  wire soc_bus_pkg::bus_strb_t i_wr_mask,

  output logic                        o_ack,
  output soc_bus_pkg::bus_word_u      o_rdata,
  output logic [`SOC_LED_W-1:0]       o_led
);

  logic [`SOC_LED_W-1:0] led_q;
  logic                  start;

  assign start = i_req && !o_ack;

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      o_ack <= 1'b0;
      led_q <= '0;
    end
    else
    begin
      o_ack <= start;
      // only lane 0 carries the led bits
      if (start && i_write && i_wr_mask[0])
        led_q <= i_wdata.bytes[0][`SOC_LED_W-1:0];
    end
  end

  assign o_rdata.word = {{(`SOC_DATA_W-`SOC_LED_W){1'b0}}, led_q};
  assign o_led        = led_q;

endmodule

`default_nettype wire

// File: design/input_port.sv
`default_nettype none

`include "soc_cfg.svh"

module input_port (
  input  wire                    clk,
  input  wire                    i_rst,

  input  wire                    i_req,
  input  wire [`SOC_KEY_W-1:0]   i_key,
  input  wire [`SOC_SW_W-1:0]    i_sw,

  output logic                   o_ack,
  output soc_bus_pkg::bus_word_u o_rdata
);

  // switches start at bit 4 of the read word
  localparam int unsigned SW_LSB = 4;

  logic [`SOC_KEY_W-1:0] key_meta;
  logic [`SOC_KEY_W-1:0] key_sync;
  logic [`SOC_SW_W-1:0]  sw_meta;
  logic [`SOC_SW_W-1:0]  sw_sync;

  // two flop synchronizer, pins are asynchronous
  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      key_meta <= '0;
      key_sync <= '0;
      sw_meta  <= '0;
      sw_sync  <= '0;
    end
    else
    begin
      key_meta <= i_key;
      key_sync <= key_meta;
      sw_meta  <= i_sw;
      sw_sync  <= sw_meta;
    end
  end

  // writes get acked like reads and change nothing
  always_ff @(posedge clk)
  begin
    if (i_rst)
      o_ack <= 1'b0;
    else
      o_ack <= i_req && !o_ack;
  end

  always_comb
  begin
    o_rdata.word                         = '0;
    o_rdata.word[`SOC_KEY_W-1:0]         = key_sync;
    o_rdata.word[SW_LSB +: `SOC_SW_W]    = sw_sync;
  end

endmodule

`default_nettype wire

// File: design/soc_top.sv
`default_nettype none

`include "soc_cfg.svh"

module soc_top (
  input  wire                         clk,
  input  wire                         i_rst,

  // master port
  input  wire                         i_req,
  input  wire                         i_write,
  input  wire soc_bus_pkg::bus_addr_t i_addr,
  input  wire soc_bus_pkg::bus_word_u i_wdata,
  input  wire soc_bus_pkg::bus_strb_t i_wr_mask,
  input  wire soc_bus_pkg::bus_strb_t i_rd_mask,
  output logic                        o_ack,
  output soc_bus_pkg::bus_word_u      o_rdata,

  // board pins
  input  wire [`SOC_KEY_W-1:0]        i_key,
  input  wire [`SOC_SW_W-1:0]         i_sw,
  output logic [`SOC_LED_W-1:0]       o_led
);

  logic                   ram_req;
  logic                   ram_ack;
  soc_bus_pkg::bus_word_u ram_rdata;

  logic                   led_req;
  logic                   led_ack;
  soc_bus_pkg::bus_word_u led_rdata;

  logic                   in_req;
  logic                   in_ack;
  soc_bus_pkg::bus_word_u in_rdata;

  bus_decoder decoder (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_req       (i_req),
    .i_addr      (i_addr),
    .i_rd_mask   (i_rd_mask),
    .i_ram_ack   (ram_ack),
    .i_ram_rdata (ram_rdata),
    .i_led_ack   (led_ack),
    .i_led_rdata (led_rdata),
    .i_in_ack    (in_ack),
    .i_in_rdata  (in_rdata),
    .o_ram_req   (ram_req),
    .o_led_req   (led_req),
    .o_in_req    (in_req),
    .o_ack       (o_ack),
    .o_rdata     (o_rdata)
  );

  scratch_ram ram (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_req     (ram_req),
    .i_write   (i_write),
    .i_addr    (i_addr),
    .i_wdata   (i_wdata),
    .i_wr_mask (i_wr_mask),
    .o_ack     (ram_ack),
    .o_rdata   (ram_rdata)
  );

  led_port leds (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_req     (led_req),
    .i_write   (i_write),
    .i_wdata   (i_wdata),
    .i_wr_mask (i_wr_mask),
    .o_ack     (led_ack),
    .o_rdata   (led_rdata),
    .o_led     (o_led)
  );

  input_port inputs (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_req   (in_req),
    .i_key   (i_key),
    .i_sw    (i_sw),
    .o_ack   (in_ack),
    .o_rdata (in_rdata)
  );

endmodule

`default_nettype wire

// File: dv/tb_soc_top.sv
`default_nettype none

`include "soc_cfg.svh"

module tb_soc_top;

  localparam int N_RAND     = 60;
  localparam int N_WORDS    = 64;
  localparam int RAM_WORDS  = 1 << `SOC_RAM_WORDS_LOG2;
  // four ram phases, then led, input, unmapped and the closing ram sweep
  localparam int N_TXNS     = 4 * N_RAND + 20 + 10 + 20 + N_WORDS;
  localparam int MAX_CYCLES = 3 * N_TXNS + 100;

  logic                   clk = 1'b0;
  logic                   i_rst;
  logic                   req;
  logic                   write;
  logic [`SOC_ADDR_W-1:0] addr;
  logic [`SOC_DATA_W-1:0] wdata;
  logic [`SOC_STRB_W-1:0] wr_mask;
  logic [`SOC_STRB_W-1:0] rd_mask;
  logic [`SOC_KEY_W-1:0]  key;
  logic [`SOC_SW_W-1:0]   sw;
  wire                    ack;
  wire [`SOC_DATA_W-1:0]  rdata;
  wire [`SOC_LED_W-1:0]   led;

  logic [`SOC_DATA_W-1:0] ram_model [RAM_WORDS];
  logic                   ram_valid [RAM_WORDS];
  logic [`SOC_LED_W-1:0]  exp_led;
  logic [`SOC_DATA_W-1:0] exp_rdata;
  logic                   chk_rdata;
  string                  test_name;
  logic [31:0]            lcg_state;
  int                     errors;
  int                     txns;
  int                     cycles = 0;

  soc_top uut (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_req     (req),
    .i_write   (write),
    .i_addr    (addr),
    .i_wdata   (wdata),
    .i_wr_mask (wr_mask),
    .i_rd_mask (rd_mask),
    .o_ack     (ack),
    .o_rdata   (rdata),
    .i_key     (key),
    .i_sw      (sw),
    .o_led     (led)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // stronger high bits of the lcg rotated down
    return {lcg_state[23:0], lcg_state[31:24]};
  endfunction

  function automatic logic [31:0] keep_lanes(input logic [31:0] word, input logic [3:0] mask);
    logic [31:0] result;
    result = '0;
    for (int lane = 0; lane < `SOC_STRB_W; lane++)
    begin
      if (mask[lane])
        result[lane*8 +: 8] = word[lane*8 +: 8];
    end
    return result;
  endfunction

  // one of the first 64 words at a random alias
  function automatic logic [31:0] ram_addr();
    logic [31:0] r;
    r = lcg_next();
    return {`SOC_REGION_RAM, r[29:10], 2'b00, r[7:2], 2'b00};
  endfunction

  task automatic idle(input int n);
    req       = 1'b0;
    chk_rdata = 1'b0;
    repeat (n)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic bus_access(input string name, input logic is_write,
                            input logic [31:0] a, input logic [31:0] d,
                            input logic [3:0] wm, input logic [3:0] rm);
    logic [`SOC_RAM_WORDS_LOG2-1:0] idx;
    logic [`SOC_DATA_W-1:0]         raw;
    idx       = a[`SOC_RAM_WORDS_LOG2+1:2];
    chk_rdata = !is_write;
    case (a[31:30])
      `SOC_REGION_RAM:
      begin
        // writes hand back the old word
        chk_rdata = ram_valid[idx];
        raw       = ram_model[idx];
      end
      `SOC_REGION_LED:
        raw = {{(`SOC_DATA_W-`SOC_LED_W){1'b0}}, exp_led};
      `SOC_REGION_INPUT:
        raw = {{(`SOC_DATA_W-8){1'b0}}, sw, {(4-`SOC_KEY_W){1'b0}}, key};
      default:
      begin
        chk_rdata = 1'b1;
        raw       = `SOC_UNMAPPED_DATA;
      end
    endcase
    test_name = name;
    exp_rdata = keep_lanes(raw, rm);
    req       = 1'b1;
    write     = is_write;
    addr      = a;
    wdata     = d;
    wr_mask   = wm;
    rd_mask   = rm;
    do
    begin
      @(posedge clk);
      #2;
    end while (!ack);
    if (is_write && a[31:30] == `SOC_REGION_RAM)
    begin
      ram_model[idx] = keep_lanes(d, wm) | keep_lanes(ram_model[idx], ~wm);
      ram_valid[idx] = ram_valid[idx] || (wm == 4'hf);
    end
    if (is_write && a[31:30] == `SOC_REGION_LED && wm[0])
      exp_led = d[`SOC_LED_W-1:0];
    @(posedge clk);
    #2;
    txns++;
  endtask

  a_reset_state: assert property (@(posedge clk) $fell(i_rst) |-> (!ack && led == '0))
    else
    begin
      errors++;
      $display("ack or led not cleared by reset");
    end

  a_ack_latency: assert property (@(posedge clk) disable iff (i_rst) (req && !ack) |=> ack)
    else
    begin
      errors++;
      $display("%s: ack missing one cycle after the request", test_name);
    end

  a_read_data: assert property (@(posedge clk) disable iff (i_rst)
    (ack && chk_rdata) |-> (rdata == exp_rdata))
    else
    begin
      errors++;
      $display("ERROR %s expected %h actual %h", test_name, exp_rdata, $sampled(rdata));
    end

  a_led_state: assert property (@(posedge clk) disable iff (i_rst) led == exp_led)
    else
    begin
      errors++;
      $display("ERROR %s led expected %h actual %h", test_name, exp_led, $sampled(led));
    end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial
  begin
    logic [31:0] r;
    lcg_state = 32'hc942c829;
    i_rst     = 1'b1;
    // an led write held through reset must not land
    req       = 1'b1;
    write     = 1'b1;
    addr      = {`SOC_REGION_LED, 30'd0};
    wdata     = 32'h0000_00a5;
    wr_mask   = 4'hf;
    rd_mask   = '0;
    key       = '0;
    sw        = '0;
    exp_led   = '0;
    exp_rdata = '0;
    chk_rdata = 1'b0;
    test_name = "reset";
    errors    = 0;
    txns      = 0;
    for (int i = 0; i < RAM_WORDS; i++)
      ram_valid[i] = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    i_rst = 1'b0;
    idle(2);

    for (int n = 0; n < N_RAND; n++)
      bus_access("ram_write", 1'b1, ram_addr(), lcg_next(), 4'hf, 4'hf);
    for (int n = 0; n < N_RAND; n++)
      bus_access("ram_read", 1'b0, ram_addr(), '0, 4'h0, 4'hf);
    for (int n = 0; n < N_RAND; n++)
    begin
      r = lcg_next();
      bus_access("ram_byte_write", 1'b1, ram_addr(), lcg_next(), r[3:0], 4'hf);
    end
    for (int n = 0; n < N_RAND; n++)
    begin
      r = lcg_next();
      bus_access("ram_masked_read", 1'b0, ram_addr(), '0, 4'h0, r[3:0]);
    end

    // lane 0 off half the time
    for (int n = 0; n < 10; n++)
    begin
      r = lcg_next();
      bus_access("led_write", 1'b1, {`SOC_REGION_LED, r[29:0]}, lcg_next(), r[3:0], 4'hf);
      bus_access("led_read", 1'b0, {`SOC_REGION_LED, r[29:0]}, '0, 4'h0, 4'hf);
    end

    for (int n = 0; n < 5; n++)
    begin
      r   = lcg_next();
      key = r[`SOC_KEY_W-1:0];
      sw  = r[`SOC_KEY_W +: `SOC_SW_W];
      // let the pins clear the synchronizer
      idle(3);
      bus_access("input_write", 1'b1, {`SOC_REGION_INPUT, r[29:0]}, lcg_next(), 4'hf, 4'hf);
      bus_access("input_read", 1'b0, {`SOC_REGION_INPUT, r[29:0]}, '0, 4'h0, r[11:8]);
    end

    for (int n = 0; n < 20; n++)
    begin
      r = lcg_next();
      bus_access("unmapped", r[31], {`SOC_REGION_UNMAPPED, r[29:0]}, lcg_next(),
                 r[3:0], r[7:4]);
    end

    // none of the traffic above may have touched the ram
    for (int n = 0; n < N_WORDS; n++)
      bus_access("ram_sweep", 1'b0, {`SOC_REGION_RAM, 22'd0, 6'(n), 2'b00}, '0, 4'h0, 4'hf);
    idle(2);

    $display("transactions %0d, errors %0d", txns, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: soc_lite.f
+incdir+design
design/soc_bus_pkg.sv
design/soc_map_pkg.sv
design/bus_decoder.sv
design/scratch_ram.sv
design/led_port.sv
design/input_port.sv
design/soc_top.sv
dv/tb_soc_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the soc_lite testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_soc_top -f soc_lite.f -o sim_soc_lite
./obj_dir/sim_soc_lite | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
